// File: rtl/spi_macros.svh
// Build-time sizing for the SPI master
// Clock ratio, FIFO depth, count widths and chip-select timing
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

////////////////////////////////////////
// Bus timing
////////////////////////////////////////

`define SPI_CLK_RATIO 8  // System clocks per SCK period, even and >= 4
`define SPI_CS_SETUP 4   // SCK periods in each select-timing state

////////////////////////////////////////
// Buffering and command widths
////////////////////////////////////////

`define SPI_FIFO_DEPTH 16  // Entries per byte FIFO
`define SPI_LEN_BITS 5     // Byte counts 0..31
`define SPI_WAIT_BITS 2    // Wait cycles 0..3

`endif

// File: rtl/spi_pkg.sv
// Shared types for the SPI master
// Byte, command, bus pins, phase strobes and bus states
`default_nettype none

`include "spi_macros.svh"

package spi_pkg;

  typedef logic [7:0] byte_t;  // One data byte

  // Command captured when go is accepted
  typedef struct packed {
    logic [`SPI_LEN_BITS-1:0]  tx_len;    // Bytes to send
    logic [`SPI_LEN_BITS-1:0]  rx_len;    // Bytes to receive
    logic [`SPI_WAIT_BITS-1:0] wait_cyc;  // Idle SCK cycles between them
  } spi_cmd_t;

  // Driven bus pins
  typedef struct packed {
    logic sck;
    logic csn;   // Active low select
    logic copi;
  } spi_bus_t;

  // One-cycle strobes at the SCK edges
  typedef struct packed {
    logic rise;
    logic fall;
  } spi_phase_t;

  // Bus sequence, Mode 0 only
  typedef enum logic [2:0] {
    ST_IDLE, ST_START_D, ST_START_S,
    ST_TX, ST_WAIT, ST_RX,
    ST_STOP_S, ST_STOP_D
  } spi_state_t;

endpackage : spi_pkg

`default_nettype wire

// File: rtl/byte_fifo.sv
// First-word-fall-through byte FIFO
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module byte_fifo (
  input  wire                 i_ext_spi_clk_x,
  input  wire                 i_srst,
  input  wire                 push_i,
  input  wire spi_pkg::byte_t data_i,
  input  wire                 pop_i,
  output spi_pkg::byte_t      data_o,   // Head entry, always visible
  output logic                empty_o,
  output logic                full_o
);

  localparam int DEPTH = `SPI_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  spi_pkg::byte_t mem [DEPTH];  // Storage
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    cnt_q;        // Occupancy 0..DEPTH
  logic           do_push;
  logic           do_pop;

  assign do_push = push_i && !full_o;   // Push while full is dropped
  assign do_pop  = pop_i && !empty_o;   // Pop while empty is dropped

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == (AW+1)'(DEPTH));
  assign data_o  = mem[rd_ptr_q];

  // Data array
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  // Pointers and count
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither keeps the count
      endcase
    end
  end

endmodule : byte_fifo

`default_nettype wire

// File: rtl/sck_phase_gen.sv
// SCK period counter with edge strobes and high-half level
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module sck_phase_gen (
  input  wire                 i_ext_spi_clk_x,
  input  wire                 i_srst,
  output spi_pkg::spi_phase_t phase_o,
  output logic                sck_high_o   // Second half of the SCK period
);

  localparam int RATIO = `SPI_CLK_RATIO;
  localparam int CW    = $clog2(RATIO);
  localparam int HALF  = RATIO / 2;

  logic [CW-1:0] cnt_q;  // 0..RATIO-1

  ////////////////////////////////////////
  // Free-running phase counter
  ////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      cnt_q <= '0;
    end else if (cnt_q == CW'(RATIO - 1)) begin
      cnt_q <= '0;  // Wrap, SCK falls here
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Rise at mid period
  assign phase_o.rise = (cnt_q == CW'(HALF));
  // Fall on last count, state updates on the wrap
  assign phase_o.fall = (cnt_q == CW'(RATIO - 1));

  assign sck_high_o = (cnt_q >= CW'(HALF));

endmodule : sck_phase_gen

`default_nettype wire

// File: rtl/spi_bus_fsm.sv
// SPI bus sequencer
// Command latch, eight-state FSM with period timer, bus drive and TX pops
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_bus_fsm (
  input  wire                 i_ext_spi_clk_x,
  input  wire                 i_srst,
  input  wire                 go_i,
  input  wire spi_pkg::spi_cmd_t   cmd_i,
  input  wire spi_pkg::spi_phase_t phase_i,
  input  wire                 sck_high_i,
  input  wire spi_pkg::byte_t tx_head_i,    // TX FIFO head
  input  wire                 tx_empty_i,
  output logic                tx_pop_o,
  output spi_pkg::spi_state_t state_o,
  output logic [2:0]          bit_idx_o,    // Bit position in current byte
  output spi_pkg::spi_bus_t   bus_o,
  output logic                idle_o
);

  // Timer wide enough for 8 periods per byte at the largest count
  localparam int TMR_W = `SPI_LEN_BITS + 3;
  localparam logic [TMR_W-1:0] CS_LAST = TMR_W'(`SPI_CS_SETUP - 1);  // Select timing length

  spi_pkg::spi_state_t state_q;
  spi_pkg::spi_state_t nx_state;
  spi_pkg::spi_cmd_t   cmd_q;      // Command of the running transaction
  logic                go_pend_q;  // Go accepted and waiting for a fall strobe
  logic [TMR_W-1:0]    tmr_q;      // SCK periods spent in this state

  logic [TMR_W-1:0]    tx_last;
  logic [TMR_W-1:0]    wait_last;
  logic [TMR_W-1:0]    rx_last;
  logic                state_end;  // Last period of the current state
  spi_pkg::spi_state_t after_start;
  spi_pkg::spi_state_t after_tx;
  spi_pkg::spi_state_t after_wait;
  logic                sck_run;

  ////////////////////////////////////////
  // State lengths and skipping
  ////////////////////////////////////////
  assign tx_last   = {cmd_q.tx_len, 3'b000} - 1'b1;
  assign wait_last = TMR_W'(cmd_q.wait_cyc) - 1'b1;
  assign rx_last   = {cmd_q.rx_len, 3'b000} - 1'b1;

  // First non-empty data phase or straight to hold
  assign after_wait  = (cmd_q.rx_len != '0) ? spi_pkg::ST_RX : spi_pkg::ST_STOP_S;
  assign after_tx    = (cmd_q.wait_cyc != '0) ? spi_pkg::ST_WAIT : after_wait;
  assign after_start = (cmd_q.tx_len != '0) ? spi_pkg::ST_TX : after_tx;

  always_comb begin
    case (state_q)
      spi_pkg::ST_TX:   state_end = (tmr_q == tx_last);
      spi_pkg::ST_WAIT: state_end = (tmr_q == wait_last);
      spi_pkg::ST_RX:   state_end = (tmr_q == rx_last);
      spi_pkg::ST_IDLE: state_end = 1'b1;
      default:          state_end = (tmr_q == CS_LAST);  // Select timing states
    endcase
  end

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    nx_state = state_q;
    case (state_q)
      spi_pkg::ST_IDLE: begin
        if (go_pend_q) nx_state = spi_pkg::ST_START_D;
      end
      spi_pkg::ST_START_D: begin
        if (state_end) nx_state = spi_pkg::ST_START_S;  // Deselected lead-in
      end
      spi_pkg::ST_START_S: begin
        if (state_end) nx_state = after_start;          // CSN low setup
      end
      spi_pkg::ST_TX: begin
        if (state_end) nx_state = after_tx;
      end
      spi_pkg::ST_WAIT: begin
        if (state_end) nx_state = after_wait;
      end
      spi_pkg::ST_RX: begin
        if (state_end) nx_state = spi_pkg::ST_STOP_S;
      end
      spi_pkg::ST_STOP_S: begin
        if (state_end) nx_state = spi_pkg::ST_STOP_D;   // CSN hold
      end
      default: begin
        if (state_end) nx_state = spi_pkg::ST_IDLE;     // Deselect gap
      end
    endcase
  end

  ////////////////////////////////////////
  // State, timer and command registers
  ////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q   <= spi_pkg::ST_IDLE;
      tmr_q     <= '0;
      go_pend_q <= 1'b0;
      cmd_q     <= '0;
    end else begin
      if (idle_o && go_i) begin
        go_pend_q <= 1'b1;
        cmd_q     <= cmd_i;  // Held for the whole transaction
      end
      if (phase_i.fall) begin
        state_q <= nx_state;
        if (nx_state != state_q || state_q == spi_pkg::ST_IDLE) begin
          tmr_q <= '0;
        end else begin
          tmr_q <= tmr_q + 1'b1;
        end
        // Only a pending go is consumed here
        if (state_q == spi_pkg::ST_IDLE && go_pend_q) go_pend_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////
  assign sck_run = (state_q == spi_pkg::ST_TX) || (state_q == spi_pkg::ST_WAIT) ||
                   (state_q == spi_pkg::ST_RX);

  assign bus_o.sck  = sck_run && sck_high_i;  // Mode 0 clock idles low
  assign bus_o.csn  = (state_q == spi_pkg::ST_IDLE) || (state_q == spi_pkg::ST_START_D) ||
                      (state_q == spi_pkg::ST_STOP_D);
  // MSB first with zeros once the TX FIFO runs dry
  assign bus_o.copi = (state_q == spi_pkg::ST_TX) && !tx_empty_i &&
                      tx_head_i[3'd7 - tmr_q[2:0]];

  // Byte done on its eighth fall strobe
  assign tx_pop_o = phase_i.fall && (state_q == spi_pkg::ST_TX) &&
                    (tmr_q[2:0] == 3'd7) && !tx_empty_i;

  assign state_o   = state_q;
  assign bit_idx_o = tmr_q[2:0];  // Data states start at zero
  assign idle_o    = (state_q == spi_pkg::ST_IDLE) && !go_pend_q;

endmodule : spi_bus_fsm

`default_nettype wire

// File: rtl/rx_byte_capture.sv
// CIPO shift register and RX FIFO write strobe
`timescale 1ns/1ps
`default_nettype none

module rx_byte_capture (
  input  wire                      i_ext_spi_clk_x,
  input  wire                      i_srst,
  input  wire spi_pkg::spi_phase_t phase_i,
  input  wire spi_pkg::spi_state_t state_i,
  input  wire [2:0]                bit_idx_i,
  input  wire                      cipo_i,
  input  wire                      fifo_full_i,
  output logic                     wr_o,    // One cycle per whole byte
  output spi_pkg::byte_t           data_o
);

  spi_pkg::byte_t shift_q;  // Bits of the byte in flight
  logic           wr_q;
  logic           sample;

  assign sample = phase_i.rise && (state_i == spi_pkg::ST_RX);

  // MSB arrives first
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (sample) shift_q <= {shift_q[6:0], cipo_i};
  end

  ////////////////////////////////////////
  // Write strobe
  ////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_q <= 1'b0;
    end else begin
      // Eighth bit completes the byte, full FIFO drops it
      wr_q <= sample && (bit_idx_i == 3'd7) && !fifo_full_i;
    end
  end

  assign wr_o   = wr_q;
  assign data_o = shift_q;  // Holds the finished byte while wr_o is high

endmodule : rx_byte_capture

`default_nettype wire

// File: rtl/spi_master_top.sv
// SPI master top level
// TX FIFO, phase generator, bus FSM, RX capture and RX FIFO
`timescale 1ns/1ps
`default_nettype none

module spi_master_top (
  input  wire                    i_ext_spi_clk_x,
  input  wire                    i_srst,
  // Host transmit side
  input  wire                    tx_push_i,
  input  wire spi_pkg::byte_t    tx_data_i,
  output logic                   tx_ready_o,   // TX FIFO not full
  // Command
  input  wire                    go_i,
  input  wire spi_pkg::spi_cmd_t cmd_i,
  output logic                   idle_o,
  // Host receive side
  input  wire                    rx_pop_i,
  output spi_pkg::byte_t         rx_data_o,
  output logic                   rx_avail_o,   // RX FIFO not empty
  // SPI pins
  output spi_pkg::spi_bus_t      bus_o,
  input  wire                    cipo_i
);

  spi_pkg::byte_t      tx_head;
  logic                tx_empty;
  logic                tx_full;
  logic                tx_pop;
  spi_pkg::spi_phase_t phase;
  logic                sck_high;
  spi_pkg::spi_state_t state;
  logic [2:0]          bit_idx;
  logic                rx_wr;
  spi_pkg::byte_t      rx_wdata;
  logic                rx_empty;
  logic                rx_full;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////
  byte_fifo u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .push_i (tx_push_i), .data_i (tx_data_i),
    .pop_i (tx_pop), .data_o (tx_head),
    .empty_o (tx_empty), .full_o (tx_full)
  );

  assign tx_ready_o = !tx_full;

  ////////////////////////////////////////
  // Bus timing and sequencing
  ////////////////////////////////////////
  sck_phase_gen u_phase (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .phase_o (phase), .sck_high_o (sck_high)
  );

  spi_bus_fsm u_fsm (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .go_i (go_i), .cmd_i (cmd_i),
    .phase_i (phase), .sck_high_i (sck_high),
    .tx_head_i (tx_head), .tx_empty_i (tx_empty), .tx_pop_o (tx_pop),
    .state_o (state), .bit_idx_o (bit_idx),
    .bus_o (bus_o), .idle_o (idle_o)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////
  rx_byte_capture u_capture (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .phase_i (phase), .state_i (state), .bit_idx_i (bit_idx),
    .cipo_i (cipo_i), .fifo_full_i (rx_full),
    .wr_o (rx_wr), .data_o (rx_wdata)
  );

  byte_fifo u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .push_i (rx_wr), .data_i (rx_wdata),
    .pop_i (rx_pop_i), .data_o (rx_data_o),
    .empty_o (rx_empty), .full_o (rx_full)
  );

  assign rx_avail_o = !rx_empty;

endmodule : spi_master_top

`default_nettype wire

// File: tests/spi_master_sva.sv
// Bus protocol assertions for the SPI master
// Bound into the top level
`timescale 1ns/1ps
`default_nettype none

module spi_master_sva (
  input wire                    i_ext_spi_clk_x,
  input wire                    i_srst,
  input wire spi_pkg::spi_bus_t bus_i,
  input wire                    idle_i
);

  // No SCK pulse while the slave is deselected
  property p_sck_quiet;
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
      bus_i.csn |-> !bus_i.sck;
  endproperty

  property p_copi_quiet;  // COPI parked low outside a select
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
      bus_i.csn |-> !bus_i.copi;
  endproperty

  property p_idle_deselect;  // Idle master never holds a select
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
      idle_i |-> bus_i.csn;
  endproperty

  a_sck_quiet:     assert property (p_sck_quiet) else $error("sck high while csn high");
  a_copi_quiet:    assert property (p_copi_quiet) else $error("copi high while csn high");
  a_idle_deselect: assert property (p_idle_deselect) else $error("idle_o with csn low");

endmodule : spi_master_sva

bind spi_master_top spi_master_sva u_sva (
  .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
  .bus_i (bus_o), .idle_i (idle_o)
);

`default_nettype wire

// File: tests/tb_spi_master.sv
// SPI master testbench
// Clock, reset, slave model, directed tests and summary
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module tb_spi_master;

  localparam int DEPTH   = `SPI_FIFO_DEPTH;
  localparam int LB      = `SPI_LEN_BITS;
  localparam int WB      = `SPI_WAIT_BITS;
  localparam int TIMEOUT = 5000;  // Clocks per wait loop

  logic              i_ext_spi_clk_x;
  logic              i_srst;
  logic              tx_push;
  spi_pkg::byte_t    tx_data;
  logic              tx_ready;
  logic              go;
  spi_pkg::spi_cmd_t cmd;
  logic              idle;
  logic              rx_pop;
  spi_pkg::byte_t    rx_data;
  logic              rx_avail;
  spi_pkg::spi_bus_t bus;
  logic              cipo;

  int             errors;
  int             tests;
  int             seed;
  bit             copi_bits[$];   // Slave view of COPI at each SCK rise
  bit             cipo_bits[$];   // Slave response stream
  spi_pkg::byte_t tx_exp[$];      // Bytes pushed for the next command
  spi_pkg::byte_t slave_resp[$];  // Bytes the slave returns in receive
  spi_pkg::byte_t rx_got[$];      // Bytes drained from the RX FIFO

  spi_master_top i_dut (
    .i_ext_spi_clk_x (i_ext_spi_clk_x), .i_srst (i_srst),
    .tx_push_i (tx_push), .tx_data_i (tx_data), .tx_ready_o (tx_ready),
    .go_i (go), .cmd_i (cmd), .idle_o (idle),
    .rx_pop_i (rx_pop), .rx_data_o (rx_data), .rx_avail_o (rx_avail),
    .bus_o (bus), .cipo_i (cipo)
  );

  always #10 i_ext_spi_clk_x = ~i_ext_spi_clk_x;  // 20 ns period

  ////////////////////////////////////////
  // Mode 0 slave model
  ////////////////////////////////////////
  function automatic bit next_cipo();
    if (cipo_bits.size() == 0) return 1'b0;  // Stream exhausted
    return cipo_bits.pop_front();
  endfunction

  always @(negedge bus.csn) begin
    copi_bits.delete();
    cipo = next_cipo();  // First bit out on select
  end
  always @(negedge bus.sck) cipo = next_cipo();
  always @(posedge bus.sck) copi_bits.push_back(bus.copi);

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
    errors++;
  endtask

  task automatic log_result(input string name, input int e0);
    tests++;
    $display("Test %s finished, %0d errors", name, errors - e0);
  endtask

  task automatic finish_run();
    $display("Summary: %0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic push_byte(input spi_pkg::byte_t b);
    tx_push = 1'b1;
    tx_data = b;
    @(posedge i_ext_spi_clk_x);
    #1 tx_push = 1'b0;
  endtask

  task automatic load_tx();
    foreach (tx_exp[i]) push_byte(tx_exp[i]);
  endtask

  task automatic fill_random(input int txn, input int rxn);
    tx_exp.delete();
    slave_resp.delete();
    for (int i = 0; i < txn; i++) tx_exp.push_back(spi_pkg::byte_t'($random(seed)));
    for (int i = 0; i < rxn; i++) slave_resp.push_back(spi_pkg::byte_t'($random(seed)));
  endtask

  // Issue a command, wait for idle, drain the RX FIFO
  task automatic run_cmd(input int rxn, input int wc);
    int n;
    cipo_bits.delete();
    for (int i = 0; i < 8 * tx_exp.size() + wc; i++) cipo_bits.push_back(1'b0);
    foreach (slave_resp[i])
      for (int b = 7; b >= 0; b--) cipo_bits.push_back(slave_resp[i][b]);
    cmd.tx_len   = LB'(tx_exp.size());
    cmd.rx_len   = LB'(rxn);
    cmd.wait_cyc = WB'(wc);
    go = 1'b1;
    @(posedge i_ext_spi_clk_x);
    #1 go = 1'b0;
    n = 0;
    while (!idle && n < TIMEOUT) begin
      @(posedge i_ext_spi_clk_x);
      #1 n++;
    end
    rx_got.delete();
    if (!idle) begin
      $display("Timeout: idle_o stayed low for %0d clocks", TIMEOUT);
      errors++;
    end else begin
      n = 0;
      while (rx_avail && n < 2 * DEPTH) begin  // Bounded drain
        rx_got.push_back(rx_data);
        rx_pop = 1'b1;
        @(posedge i_ext_spi_clk_x);
        #1 rx_pop = 1'b0;
        n++;
      end
    end
  endtask

  // Rise count, bytes seen by the slave, bytes left in the RX FIFO
  task automatic check_xfer(input string name, input int rxn, input int wc);
    int             rises;
    int             nrx;
    spi_pkg::byte_t b;
    rises = 8 * tx_exp.size() + wc + 8 * rxn;
    nrx   = (rxn < DEPTH) ? rxn : DEPTH;  // Overflow bytes dropped
    if (copi_bits.size() != rises) report_mismatch({name, " rises"}, rises, copi_bits.size());
    foreach (tx_exp[i]) begin
      for (int k = 0; k < 8; k++) b[7 - k] = copi_bits[8 * i + k];
      if (b !== tx_exp[i]) report_mismatch({name, " tx byte"}, tx_exp[i], b);
    end
    if (rx_got.size() != nrx) report_mismatch({name, " rx count"}, nrx, rx_got.size());
    for (int i = 0; i < nrx && i < rx_got.size(); i++)
      if (rx_got[i] !== slave_resp[i]) report_mismatch({name, " rx byte"}, slave_resp[i], rx_got[i]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic reset_values();
    int e0;
    e0 = errors;
    if (bus.csn !== 1'b1) report_mismatch("reset csn", 1, bus.csn);
    if (bus.sck !== 1'b0) report_mismatch("reset sck", 0, bus.sck);
    if (idle !== 1'b1) report_mismatch("reset idle_o", 1, idle);
    if (tx_ready !== 1'b1) report_mismatch("reset tx_ready_o", 1, tx_ready);
    if (rx_avail !== 1'b0) report_mismatch("reset rx_avail_o", 0, rx_avail);
    log_result("reset", e0);
  endtask

  task automatic write_only();
    int e0;
    e0 = errors;
    tx_exp = '{8'h3C, 8'hA5, 8'h81};
    slave_resp.delete();
    load_tx();
    run_cmd(0, 0);
    check_xfer("write_only", 0, 0);  // Empty drain means rx_avail_o stayed low
    log_result("write_only", e0);
  endtask

  task automatic write_read(input string name, input int wc);
    int e0;
    e0 = errors;
    tx_exp     = '{8'h9F, 8'h0B};
    slave_resp = '{8'hC2, 8'h5B};
    if (wc == 0) void'(tx_exp.pop_back());  // One-byte opcode
    load_tx();
    run_cmd(2, wc);
    check_xfer(name, 2, wc);
    log_result(name, e0);
  endtask

  task automatic random_xfers();
    int e0;
    int txn;
    int rxn;
    int wc;
    e0 = errors;
    for (int t = 0; t < 6; t++) begin
      txn = 1 + ($random(seed) & 3);
      rxn = 1 + ($random(seed) & 3);
      wc  = $random(seed) & 3;
      fill_random(txn, rxn);
      load_tx();
      run_cmd(rxn, wc);
      check_xfer("random", rxn, wc);
    end
    log_result("random", e0);
  endtask

  task automatic back_pressure();
    int e0;
    e0 = errors;
    fill_random(DEPTH, 20);
    load_tx();
    if (tx_ready !== 1'b0) report_mismatch("back_pressure tx_ready_o", 0, tx_ready);
    push_byte(8'hEE);  // TX FIFO full so this push is refused
    run_cmd(20, 0);
    check_xfer("back_pressure", 20, 0);
    log_result("back_pressure", e0);
  endtask

  initial begin
    i_ext_spi_clk_x = 1'b0;
    i_srst  = 1'b1;
    tx_push = 1'b0;
    tx_data = '0;
    go      = 1'b0;
    cmd     = '0;
    rx_pop  = 1'b0;
    cipo    = 1'b0;
    errors  = 0;
    tests   = 0;
    seed    = 58;
    repeat (2) @(posedge i_ext_spi_clk_x);
    #1 i_srst = 1'b0;
    reset_values();
    write_only();
    write_read("write_read", 0);
    write_read("wait_cycles", 2);
    random_xfers();
    back_pressure();
    finish_run();
  end

endmodule : tb_spi_master

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/byte_fifo.sv
rtl/sck_phase_gen.sv
rtl/spi_bus_fsm.sv
rtl/rx_byte_capture.sv
rtl/spi_master_top.sv
tests/spi_master_sva.sv
tests/tb_spi_master.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_spi_master -f vlog.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
